// ==== verilog/eeprom_defs.svh ====
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// array address, block bits above one address byte
`define EE_ADDR_W 11

`define EE_DEPTH 2048

// upper nibble of every control byte
`define EE_DEV_CODE 4'b1010

// flops per bus line before edge detection
`define EE_SYNC_STAGES 2

`endif

// ==== verilog/eeprom_pkg.sv ====
package eeprom_pkg;

    // control byte as sent on the bus, msb first
    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] block;
        logic       rnw;
    } ctrl_fields_t;

    // one received byte, seen as control fields or as address/data
    typedef union packed {
        ctrl_fields_t ctrl;
        logic [7:0]   raw;
    } rx_byte_u;

    // strobes from the bit-level front end
    typedef struct packed {
        logic     start;
        logic     stop;
        logic     byte_done;
        logic     ack_slot_end;
        logic     master_ack;
        rx_byte_u data;
    } bus_event_t;

    typedef enum logic [2:0] {
        IDLE,
        GET_CTRL,
        GET_ADDR,
        GET_DATA,
        SEND_DATA,
        WAIT_ACK,
        IGNORE
    } ctrl_state_e;

endpackage

// ==== verilog/eeprom_array.sv ====
`include "eeprom_defs.svh"

module eeprom_array
(
    input  logic                  scl,
    input  logic                  we,
    input  logic [`EE_ADDR_W-1:0] waddr,
    input  logic [7:0]            wdata,
    input  logic                  re,
    input  logic [`EE_ADDR_W-1:0] raddr,
    output logic [7:0]            rdata
);

    logic [7:0] mem [`EE_DEPTH];

    always_ff @(posedge scl)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // one-cycle registered read
    always_ff @(posedge scl)
    begin
        if (re)
        begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== verilog/i2c_slave_phy.sv ====
`include "eeprom_defs.svh"

module i2c_slave_phy
    import eeprom_pkg::*;
(
    input  logic       scl,
    input  logic       arst_n,
    input  logic       i2c_clk,
    input  logic       i2c_dat,
    input  logic       ack_req,
    input  logic       tx_load,
    input  logic [7:0] tx_byte,
    input  logic       tx_active,
    output bus_event_t evt,
    output logic       sda_pull
);

    logic [`EE_SYNC_STAGES-1:0] clk_sync;
    logic [`EE_SYNC_STAGES-1:0] dat_sync;
    logic                       clk_s;
    logic                       dat_s;
    logic                       clk_d;
    logic                       dat_d;
    logic                       clk_rise;
    logic                       clk_fall;
    logic                       start_det;
    logic                       stop_det;
    logic [3:0]                 bit_cnt;
    logic [7:0]                 rx_shift;
    logic [7:0]                 tx_shift;
    logic                       tx_pend;
    logic                       tx_on;
    logic                       ack_sample;

    // idle bus reads high
    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clk_sync <= {`EE_SYNC_STAGES{1'b1}};
            dat_sync <= {`EE_SYNC_STAGES{1'b1}};
            clk_d    <= 1'b1;
            dat_d    <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[`EE_SYNC_STAGES-2:0], i2c_clk};
            dat_sync <= {dat_sync[`EE_SYNC_STAGES-2:0], i2c_dat};
            clk_d    <= clk_s;
            dat_d    <= dat_s;
        end
    end

    assign clk_s     = clk_sync[`EE_SYNC_STAGES-1];
    assign dat_s     = dat_sync[`EE_SYNC_STAGES-1];
    assign clk_rise  = clk_s & ~clk_d;
    assign clk_fall  = ~clk_s & clk_d;
    assign start_det = clk_s & clk_d & dat_d & ~dat_s;
    assign stop_det  = clk_s & clk_d & ~dat_d & dat_s;

    // bit_cnt counts rising clocks, 9 means inside the ack clock
    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            evt        <= '0;
            bit_cnt    <= 4'd0;
            rx_shift   <= 8'h00;
            tx_shift   <= 8'h00;
            tx_pend    <= 1'b0;
            tx_on      <= 1'b0;
            ack_sample <= 1'b0;
            sda_pull   <= 1'b0;
        end
        else
        begin
            evt.start        <= start_det;
            evt.stop         <= stop_det;
            evt.byte_done    <= 1'b0;
            evt.ack_slot_end <= 1'b0;
            evt.master_ack   <= 1'b0;
            if (tx_load)
            begin
                tx_shift <= tx_byte;
                tx_pend  <= 1'b1;
            end
            if (start_det || stop_det)
            begin
                bit_cnt  <= 4'd0;
                tx_pend  <= 1'b0;
                tx_on    <= 1'b0;
                sda_pull <= 1'b0;
            end
            else if (clk_rise)
            begin
                if (bit_cnt < 4'd8)
                begin
                    rx_shift <= {rx_shift[6:0], dat_s};
                    bit_cnt  <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7)
                    begin
                        evt.byte_done <= 1'b1;
                        evt.data.raw  <= {rx_shift[6:0], dat_s};
                    end
                end
                else if (bit_cnt == 4'd8)
                begin
                    // low line on the ninth clock is an ack
                    ack_sample <= ~dat_s;
                    bit_cnt    <= 4'd9;
                end
            end
            else if (clk_fall)
            begin
                if (bit_cnt == 4'd8)
                begin
                    sda_pull <= ack_req;
                    tx_on    <= 1'b0;
                end
                else if (bit_cnt == 4'd9)
                begin
                    bit_cnt          <= 4'd0;
                    evt.ack_slot_end <= 1'b1;
                    evt.master_ack   <= ack_sample;
                    if (tx_active && tx_pend)
                    begin
                        sda_pull <= ~tx_shift[7];
                        tx_on    <= 1'b1;
                        tx_pend  <= 1'b0;
                    end
                    else
                    begin
                        sda_pull <= 1'b0;
                    end
                end
                else if (tx_on && tx_active && bit_cnt != 4'd0)
                begin
                    sda_pull <= ~tx_shift[6];
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== verilog/eeprom_ctrl.sv ====
`include "eeprom_defs.svh"

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  logic                  scl,
    input  logic                  arst_n,
    input  bus_event_t            evt,
    input  logic [7:0]            rdata,
    output logic                  ack_req,
    output logic                  tx_load,
    output logic [7:0]            tx_byte,
    output logic                  tx_active,
    output logic                  we,
    output logic [`EE_ADDR_W-1:0] waddr,
    output logic [7:0]            wdata,
    output logic                  re,
    output logic [`EE_ADDR_W-1:0] raddr
);

    ctrl_state_e           state;
    logic [`EE_ADDR_W-1:0] ptr;
    logic [2:0]            blk;
    logic [`EE_ADDR_W-1:0] rd_addr;
    logic                  byte_in;
    logic                  dev_match;
    logic                  rd_hit;
    logic                  wr_hit;
    logic                  addr_in;
    logic                  data_in;

    assign byte_in   = evt.byte_done & ~evt.start & ~evt.stop;
    assign dev_match = (evt.data.ctrl.dev_code == `EE_DEV_CODE);
    assign rd_hit    = byte_in && state == GET_CTRL && dev_match && evt.data.ctrl.rnw;
    assign wr_hit    = byte_in && state == GET_CTRL && dev_match && !evt.data.ctrl.rnw;
    assign addr_in   = byte_in && state == GET_ADDR;
    assign data_in   = byte_in && state == GET_DATA;

    // read block comes from the control byte, low byte from the pointer
    assign rd_addr = {evt.data.ctrl.block, ptr[7:0]};

    // array output is registered, so it is valid together with tx_load
    assign tx_byte = rdata;

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= IDLE;
            ptr       <= '0;
            ack_req   <= 1'b0;
            tx_load   <= 1'b0;
            tx_active <= 1'b0;
            we        <= 1'b0;
            re        <= 1'b0;
        end
        else
        begin
            we      <= data_in;
            re      <= rd_hit;
            tx_load <= re;
            if (evt.ack_slot_end)
            begin
                ack_req <= 1'b0;
            end
            if (evt.stop)
            begin
                state     <= IDLE;
                tx_active <= 1'b0;
                ack_req   <= 1'b0;
            end
            else if (evt.start)
            begin
                state     <= GET_CTRL;
                tx_active <= 1'b0;
                ack_req   <= 1'b0;
            end
            else if (rd_hit)
            begin
                ack_req   <= 1'b1;
                tx_active <= 1'b1;
                ptr       <= rd_addr + 1'b1;
                state     <= SEND_DATA;
            end
            else if (wr_hit)
            begin
                ack_req <= 1'b1;
                state   <= GET_ADDR;
            end
            else if (addr_in)
            begin
                ack_req <= 1'b1;
                ptr     <= {blk, evt.data.raw};
                state   <= GET_DATA;
            end
            else if (data_in)
            begin
                // no page writes, later bytes get no ack
                ack_req <= 1'b1;
                ptr     <= ptr + 1'b1;
                state   <= IGNORE;
            end
            else if (byte_in && state == GET_CTRL)
            begin
                state <= IGNORE;
            end
            else if (byte_in && state == SEND_DATA)
            begin
                state <= WAIT_ACK;
            end
            else if (evt.ack_slot_end && state == WAIT_ACK)
            begin
                // an ack asks for a second byte, which is not served
                tx_active <= 1'b0;
                state     <= evt.master_ack ? IGNORE : IDLE;
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (wr_hit)
        begin
            blk <= evt.data.ctrl.block;
        end
        if (rd_hit)
        begin
            raddr <= rd_addr;
        end
        if (data_in)
        begin
            waddr <= ptr;
            wdata <= evt.data.raw;
        end
    end

endmodule

// ==== verilog/i2c_eeprom_top.sv ====
`include "eeprom_defs.svh"

module i2c_eeprom_top
    import eeprom_pkg::*;
(
    input  logic scl,
    input  logic arst_n,
    input  logic i2c_clk,
    input  logic i2c_dat,
    output logic sda_pull
);

    bus_event_t            evt;
    logic                  ack_req;
    logic                  tx_load;
    logic [7:0]            tx_byte;
    logic                  tx_active;
    logic                  we;
    logic [`EE_ADDR_W-1:0] waddr;
    logic [7:0]            wdata;
    logic                  re;
    logic [`EE_ADDR_W-1:0] raddr;
    logic [7:0]            rdata;

    i2c_slave_phy u_phy
    (
        .scl       (scl),
        .arst_n    (arst_n),
        .i2c_clk   (i2c_clk),
        .i2c_dat   (i2c_dat),
        .ack_req   (ack_req),
        .tx_load   (tx_load),
        .tx_byte   (tx_byte),
        .tx_active (tx_active),
        .evt       (evt),
        .sda_pull  (sda_pull)
    );

    eeprom_ctrl u_ctrl
    (
        .scl       (scl),
        .arst_n    (arst_n),
        .evt       (evt),
        .rdata     (rdata),
        .ack_req   (ack_req),
        .tx_load   (tx_load),
        .tx_byte   (tx_byte),
        .tx_active (tx_active),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .re        (re),
        .raddr     (raddr)
    );

    eeprom_array u_array
    (
        .scl   (scl),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .re    (re),
        .raddr (raddr),
        .rdata (rdata)
    );

endmodule

// ==== dv/eeprom_checker.sv ====
module eeprom_checker
(
    input  logic       scl,
    input  logic       i2c_clk,
    input  logic       sda_line,
    input  logic       sda_pull,
    input  logic       quiet,
    input  logic       exp_valid,
    input  logic       exp_kind,
    input  logic [7:0] exp_value,
    output int         err_cnt,
    output int         chk_cnt
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] rx_shift;
    int         rx_bits;
    int         cmp_err;
    int         pull_err;

    assign err_cnt = cmp_err + pull_err;

    initial
    begin
        cmp_err  = 0;
        pull_err = 0;
        chk_cnt  = 0;
        rx_shift = 8'h00;
        rx_bits  = 0;
    end

    // bus lines are stable around the rising bus clock
    always @(posedge i2c_clk)
    begin
        if (exp_valid && !exp_kind)
        begin
            rx_bits = 0;
            chk_cnt++;
            if (~sda_line != exp_value[0])
            begin
                cmp_err++;
                $display("** Error: sda_line ack expected %h actual %h",
                         exp_value[0], ~sda_line);
            end
        end
        else if (exp_valid && exp_kind)
        begin
            rx_shift = {rx_shift[6:0], sda_line};
            rx_bits++;
            if (rx_bits == 8)
            begin
                rx_bits = 0;
                chk_cnt++;
                if (rx_shift != exp_value)
                begin
                    cmp_err++;
                    $display("** Error: sda_line read byte expected %h actual %h",
                             exp_value, rx_shift);
                end
            end
        end
        else
        begin
            rx_bits = 0;
        end
    end

    // foreign device traffic must leave the line alone
    always @(posedge scl)
    begin
        if (quiet && sda_pull)
        begin
            pull_err++;
            $display("sda_pull asserted during a transfer to a foreign device");
        end
    end

endmodule

// ==== dv/tb_i2c_eeprom.sv ====
`include "eeprom_defs.svh"

module tb_i2c_eeprom;

    timeunit 1ns;
    timeprecision 100ps;

    logic                  scl;
    logic                  arst_n;
    logic                  m_clk;
    logic                  m_pull;
    logic                  quiet;
    logic                  exp_valid;
    logic                  exp_kind;
    logic [7:0]            exp_value;
    wire                   sda_pull;
    wire                   sda_line;
    int                    err_cnt;
    int                    chk_cnt;
    logic [31:0]           seed;
    logic [`EE_ADDR_W-1:0] ptr_model;
    logic [7:0]            shadow [`EE_DEPTH];
    bit                    used [`EE_DEPTH];
    logic [7:0]            op_q [$];
    logic [31:0]           arg_q [$];
    longint                limit_ns;

    // open-drain data line, master or slave may pull it low
    assign sda_line = ~(m_pull | sda_pull);

    always #20 scl = ~scl;

    i2c_eeprom_top u_i2c_eeprom_top
    (
        .scl      (scl),
        .arst_n   (arst_n),
        .i2c_clk  (m_clk),
        .i2c_dat  (sda_line),
        .sda_pull (sda_pull)
    );

    eeprom_checker u_checker
    (
        .scl       (scl),
        .i2c_clk   (m_clk),
        .sda_line  (sda_line),
        .sda_pull  (sda_pull),
        .quiet     (quiet),
        .exp_valid (exp_valid),
        .exp_kind  (exp_kind),
        .exp_value (exp_value),
        .err_cnt   (err_cnt),
        .chk_cnt   (chk_cnt)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // all bus line changes land 2 ns after a rising system clock
    task automatic cyc(input int n);
        repeat (n) @(posedge scl);
        #2;
    endtask

    task automatic bus_start();
        cyc(16);
        m_pull = 1'b1;
        cyc(16);
        m_clk = 1'b0;
    endtask

    task automatic bus_rep_start();
        cyc(8);
        m_pull = 1'b0;
        cyc(8);
        m_clk = 1'b1;
        cyc(16);
        m_pull = 1'b1;
        cyc(16);
        m_clk = 1'b0;
    endtask

    task automatic bus_stop();
        cyc(8);
        m_pull = 1'b1;
        cyc(8);
        m_clk = 1'b1;
        cyc(16);
        m_pull = 1'b0;
        cyc(16);
    endtask

    task automatic send_bit(input logic b);
        cyc(8);
        m_pull = ~b;
        cyc(8);
        m_clk = 1'b1;
        cyc(16);
        m_clk = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b, input logic ack);
        for (int i = 7; i >= 0; i--)
        begin
            send_bit(b[i]);
        end
        // ninth clock, line released for the slave
        cyc(8);
        m_pull    = 1'b0;
        exp_valid = 1'b1;
        exp_kind  = 1'b0;
        exp_value = {7'd0, ack};
        cyc(8);
        m_clk = 1'b1;
        cyc(16);
        m_clk     = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic recv_byte(input logic [7:0] expected);
        repeat (8)
        begin
            cyc(8);
            m_pull    = 1'b0;
            exp_valid = 1'b1;
            exp_kind  = 1'b1;
            exp_value = expected;
            cyc(8);
            m_clk = 1'b1;
            cyc(16);
            m_clk = 1'b0;
        end
        exp_valid = 1'b0;
        // single byte reads end with a nack
        send_bit(1'b1);
    endtask

    task automatic do_write(input logic [3:0] dev, input logic [2:0] blk,
                            input logic [7:0] addr, input logic [7:0] data,
                            input logic [2:0] mask);
        bus_start();
        quiet = (dev != `EE_DEV_CODE);
        send_byte({dev, blk, 1'b0}, mask[2]);
        send_byte(addr, mask[1]);
        send_byte(data, mask[0]);
        bus_stop();
        quiet = 1'b0;
        if (dev == `EE_DEV_CODE)
        begin
            shadow[{blk, addr}] = data;
            ptr_model = {blk, addr} + 1'b1;
        end
    endtask

    task automatic do_rand_read(input logic [2:0] blk, input logic [7:0] addr,
                                input logic [7:0] expected);
        bus_start();
        send_byte({`EE_DEV_CODE, blk, 1'b0}, 1'b1);
        send_byte(addr, 1'b1);
        bus_rep_start();
        send_byte({`EE_DEV_CODE, blk, 1'b1}, 1'b1);
        recv_byte(expected);
        bus_stop();
        ptr_model = {blk, addr} + 1'b1;
    endtask

    task automatic do_cur_read(input logic [7:0] expected);
        bus_start();
        send_byte({`EE_DEV_CODE, ptr_model[10:8], 1'b1}, 1'b1);
        recv_byte(expected);
        bus_stop();
        ptr_model = ptr_model + 1'b1;
    endtask

    task automatic do_abort(input logic [2:0] blk, input logic [7:0] addr);
        bus_start();
        send_byte({`EE_DEV_CODE, blk, 1'b0}, 1'b1);
        send_byte(addr, 1'b1);
        bus_stop();
        ptr_model = {blk, addr};
    endtask

    task automatic lcg_sweep(input int n);
        logic [10:0] addr_list [$];
        logic [10:0] a;
        logic [7:0]  d;
        for (int i = 0; i < n; i++)
        begin
            do
            begin
                seed = lcg_next(seed);
                a    = seed[26:16];
            end
            while (used[a]);
            used[a] = 1'b1;
            seed    = lcg_next(seed);
            d       = seed[23:16];
            addr_list.push_back(a);
            do_write(`EE_DEV_CODE, a[10:8], a[7:0], d, 3'b111);
        end
        foreach (addr_list[i])
        begin
            do_rand_read(addr_list[i][10:8], addr_list[i][7:0], shadow[addr_list[i]]);
        end
    endtask

    // cases file, one op per line, arguments in hex
    task automatic load_cases();
        int                fd;
        int                code;
        logic [7:0]        op;
        logic [31:0]       v [5];
        logic [8*128-1:0]  line;
        longint            total;
        total = 0;
        fd = $fopen("dv/eeprom_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the cases file dv/eeprom_cases.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fscanf(fd, " %c", op);
                if (code != 1)
                begin
                    break;
                end
                v = '{default: 32'd0};
                case (op)
                    "#": code = $fgets(line, fd);
                    "W": code = $fscanf(fd, "%h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]);
                    "R": code = $fscanf(fd, "%h %h %h", v[0], v[1], v[2]);
                    "A": code = $fscanf(fd, "%h %h", v[0], v[1]);
                    default: code = $fscanf(fd, "%h", v[0]);
                endcase
                if (op != "#")
                begin
                    op_q.push_back(op);
                    for (int i = 0; i < 5; i++)
                    begin
                        arg_q.push_back(v[i]);
                    end
                    total += (op == "L") ? 4 * v[0] * 40 * 32 * 40 : 2 * 40 * 32 * 40;
                end
            end
            $fclose(fd);
            limit_ns = total;
        end
    endtask

    initial
    begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout: the bus transactions did not finish in the expected time");
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        logic [31:0] a [5];
        scl       = 1'b0;
        arst_n    = 1'b0;
        m_clk     = 1'b1;
        m_pull    = 1'b0;
        quiet     = 1'b0;
        exp_valid = 1'b0;
        exp_kind  = 1'b0;
        exp_value = 8'h00;
        seed      = 32'h93ed_2ab1;
        ptr_model = '0;
        limit_ns  = 0;
        load_cases();
        repeat (3) @(posedge scl);
        #2;
        arst_n = 1'b1;
        foreach (op_q[k])
        begin
            for (int i = 0; i < 5; i++)
            begin
                a[i] = arg_q[k * 5 + i];
            end
            case (op_q[k])
                "W": do_write(a[0][3:0], a[1][2:0], a[2][7:0], a[3][7:0], a[4][2:0]);
                "R": do_rand_read(a[0][2:0], a[1][7:0], a[2][7:0]);
                "C": do_cur_read(a[0][7:0]);
                "A": do_abort(a[0][2:0], a[1][7:0]);
                "L": lcg_sweep(int'(a[0]));
                default: $display("unknown op in the cases file, skipped");
            endcase
        end
        cyc(16);
        $display("errors %0d, checks %0d", err_cnt, chk_cnt);
        if (err_cnt == 0 && chk_cnt > 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/eeprom_cases.txt ====
# W dev blk addr data ackmask | R blk addr expected | C expected | A blk addr | L count
# all values hex, ackmask bits are control, address, data with 1 for an expected ack
W a 0 40 10 7
W a 1 40 21 7
W a 2 40 32 7
W a 3 40 43 7
W a 4 40 54 7
W a 5 40 65 7
W a 6 40 76 7
W a 7 40 87 7
R 0 40 10
R 1 40 21
R 2 40 32
R 3 40 43
R 4 40 54
R 5 40 65
R 6 40 76
R 7 40 87
W a 3 00 6f 7
W a 2 ff 5e 7
C 6f
W a 0 00 3c 7
W a 7 ff 99 7
C 3c
W 6 7 40 ee 0
R 7 40 87
A 3 00
R 3 00 6f
L 10

// ==== tb.f ====
+incdir+verilog
verilog/eeprom_pkg.sv
verilog/eeprom_array.sv
verilog/i2c_slave_phy.sv
verilog/eeprom_ctrl.sv
verilog/i2c_eeprom_top.sv
dv/eeprom_checker.sv
dv/tb_i2c_eeprom.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_i2c_eeprom -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
